// File: audio_synthesis.f
+incdir+verif
rtl/synth_pkg.sv
rtl/adsr_modulator.sv
rtl/custom_wave_table.sv
rtl/wave_oscillator.sv
rtl/gain_mixer.sv
rtl/audio_generation_pipeline.sv
rtl/audio_synthesis_pipeline.sv
verif/audio_synthesis_tb.sv

// File: rtl/adsr_modulator.sv
`timescale 1ns/1ps
`default_nettype none

module adsr_modulator (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        start_i,
    input  logic                        enable_i,
    input  logic [synth_pkg::ENV_W-1:0] attack_step_i,
    input  logic [synth_pkg::ENV_W-1:0] decay_step_i,
    input  logic [synth_pkg::ENV_W-1:0] release_step_i,
    input  logic [synth_pkg::ENV_W-1:0] sustain_duration_i,
    input  logic [synth_pkg::ENV_W-1:0] attack_level_i,
    input  logic [synth_pkg::ENV_W-1:0] sustain_level_i,
    output logic                        idle_o,
    output logic [synth_pkg::GAIN_W-1:0] modulator_o
);
    import synth_pkg::*;

    adsr_state_e      state_q, state_d;
    logic [ENV_W-1:0] level_q, level_d;
    logic [ENV_W-1:0] sustain_cnt_q, sustain_cnt_d;
    logic [ENV_W:0]   attack_sum;    // Extra bit catches a wrapping add
    logic [ENV_W:0]   decay_floor;

    always_comb begin
        state_d       = state_q;
        level_d       = level_q;
        sustain_cnt_d = '0;
        attack_sum    = {1'b0, level_q} + {1'b0, attack_step_i};
        decay_floor   = {1'b0, sustain_level_i} + {1'b0, decay_step_i};

        if (!enable_i) begin
            state_d = ADSR_IDLE;
            level_d = '0;
        end else if (start_i) begin
            state_d = ADSR_ATTACK;   // Restart keeps the current level
        end else begin
            case (state_q)
                ADSR_ATTACK: begin
                    if (attack_sum >= {1'b0, attack_level_i}) begin
                        level_d = attack_level_i;
                        state_d = ADSR_DECAY;
                    end else begin
                        level_d = attack_sum[ENV_W-1:0];
                    end
                end
                ADSR_DECAY: begin
                    if ({1'b0, level_q} <= decay_floor) begin
                        level_d = sustain_level_i;
                        state_d = ADSR_SUSTAIN;
                    end else begin
                        level_d = level_q - decay_step_i;
                    end
                end
                ADSR_SUSTAIN: begin
                    sustain_cnt_d = sustain_cnt_q + 1'b1;
                    if (sustain_cnt_d >= sustain_duration_i) state_d = ADSR_RELEASE;
                end
                ADSR_RELEASE: begin
                    if (level_q <= release_step_i) begin
                        level_d = '0;
                        state_d = ADSR_IDLE;
                    end else begin
                        level_d = level_q - release_step_i;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= ADSR_IDLE;
            level_q       <= '0;
            sustain_cnt_q <= '0;
            idle_o        <= 1'b1;
        end else begin
            state_q       <= state_d;
            level_q       <= level_d;
            sustain_cnt_q <= sustain_cnt_d;
            idle_o        <= (state_d == ADSR_IDLE);   // Registered alongside the state
        end
    end

    assign modulator_o = level_q[ENV_W-1 -: GAIN_W];

    // The clamp in ATTACK keeps the level at or below the target
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        state_q == ADSR_ATTACK |-> level_q <= attack_level_i);

    // Every way into IDLE leaves the envelope silent
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        idle_o |-> level_q == '0);

endmodule : adsr_modulator

`default_nettype wire

// File: rtl/audio_generation_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module audio_generation_pipeline #(
    parameter int TABLE_ADDR_W = 10
) (
    input  logic clk_i,
    input  logic rst_n_i,

    // Custom table writes
    input  logic                                                      write_table_i,
    input  logic [TABLE_ADDR_W-1:0]                                   table_addr_i,
    input  logic signed [synth_pkg::SAMPLE_W-1:0]                     pcm_i,

    // Per-voice control
    input  logic [synth_pkg::NUM_VOICES-1:0]                          wave_enable_i,
    input  logic [synth_pkg::NUM_VOICES-1:0]                          wave_start_i,
    input  logic [synth_pkg::NUM_VOICES-1:0][synth_pkg::PHASE_W-1:0]  wave_frequency_i,
    input  logic [synth_pkg::PHASE_W-1:0]                             square_wave_duty_cycle_i,
    input  logic [synth_pkg::NUM_VOICES-1:0][synth_pkg::GAIN_W-1:0]   wave_gain_i,

    output logic signed [synth_pkg::SAMPLE_W-1:0]                     mixed_wave_o
);
    import synth_pkg::*;

    logic [TABLE_ADDR_W-1:0]                osc_addr [NUM_VOICES];
    logic signed [SAMPLE_W-1:0]             table_rdata;
    logic [NUM_VOICES-1:0][SAMPLE_W-1:0]    raw_sample;
    logic [NUM_VOICES-1:0][GAIN_W-1:0]      gain_q;

    // ##########################################################
    // Oscillators
    // ##########################################################

    genvar v;
    generate
        for (v = 0; v < NUM_VOICES; v++) begin : g_voice
            wave_oscillator #(
                .SHAPE        ( wave_shape_e'(v) ),   // Voice index selects the shape
                .TABLE_ADDR_W ( TABLE_ADDR_W     )
            ) u_oscillator (
                .clk_i        ( clk_i                    ),
                .rst_n_i      ( rst_n_i                  ),
                .enable_i     ( wave_enable_i[v]         ),
                .start_i      ( wave_start_i[v]          ),
                .frequency_i  ( wave_frequency_i[v]      ),
                .duty_cycle_i ( square_wave_duty_cycle_i ),
                .table_data_i ( table_rdata              ),
                .table_addr_o ( osc_addr[v]              ),
                .sample_o     ( raw_sample[v]            )
            );
        end
    endgenerate

    custom_wave_table #(
        .TABLE_ADDR_W ( TABLE_ADDR_W )
    ) u_custom_wave_table (
        .clk_i        ( clk_i                 ),
        .write_i      ( write_table_i         ),
        .write_addr_i ( table_addr_i          ),
        .read_addr_i  ( osc_addr[CUSTOM_WAVE] ),
        .write_data_i ( pcm_i                 ),
        .read_data_o  ( table_rdata           )
    );

    // ##########################################################
    // Mixing
    // ##########################################################

    always_ff @(posedge clk_i) begin
        gain_q <= wave_gain_i;   // Lines the gains up with the registered samples
    end

    gain_mixer u_gain_mixer (
        .clk_i    ( clk_i        ),
        .rst_n_i  ( rst_n_i      ),
        .sample_i ( raw_sample   ),
        .gain_i   ( gain_q       ),
        .mixed_o  ( mixed_wave_o )
    );

endmodule : audio_generation_pipeline

`default_nettype wire

// File: rtl/audio_synthesis_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module audio_synthesis_pipeline #(
    parameter int TABLE_ADDR_W = 10
) (
    input  logic clk_i,
    input  logic rst_n_i,

    // Envelope control
    input  logic [synth_pkg::NUM_VOICES-1:0]                         adsr_start_i,
    input  logic [synth_pkg::NUM_VOICES-1:0]                         adsr_enable_i,
    input  logic [synth_pkg::NUM_VOICES-1:0][synth_pkg::ENV_W-1:0]   attack_step_i,
    input  logic [synth_pkg::NUM_VOICES-1:0][synth_pkg::ENV_W-1:0]   decay_step_i,
    input  logic [synth_pkg::NUM_VOICES-1:0][synth_pkg::ENV_W-1:0]   release_step_i,
    input  logic [synth_pkg::NUM_VOICES-1:0][synth_pkg::ENV_W-1:0]   sustain_duration_i,
    input  logic [synth_pkg::NUM_VOICES-1:0][synth_pkg::ENV_W-1:0]   attack_level_i,
    input  logic [synth_pkg::NUM_VOICES-1:0][synth_pkg::ENV_W-1:0]   sustain_level_i,
    output logic [synth_pkg::NUM_VOICES-1:0]                         adsr_idle_o,

    // Custom table writes
    input  logic                                                     write_table_i,
    input  logic [TABLE_ADDR_W-1:0]                                  table_addr_i,
    input  logic signed [synth_pkg::SAMPLE_W-1:0]                    pcm_i,

    // Oscillator control
    input  logic [synth_pkg::NUM_VOICES-1:0]                         wave_enable_i,
    input  logic [synth_pkg::NUM_VOICES-1:0]                         wave_start_i,
    input  logic [synth_pkg::NUM_VOICES-1:0][synth_pkg::PHASE_W-1:0] wave_frequency_i,
    input  logic [synth_pkg::PHASE_W-1:0]                            square_wave_duty_cycle_i,
    input  logic [synth_pkg::NUM_VOICES-1:0][synth_pkg::GAIN_W-1:0]  wave_gain_i,

    output logic signed [synth_pkg::SAMPLE_W-1:0]                    mixed_wave_o
);
    import synth_pkg::*;

    logic [NUM_VOICES-1:0][GAIN_W-1:0] envelope;
    logic [NUM_VOICES-1:0][GAIN_W-1:0] wave_gain;

    // ##########################################################
    // Envelopes and gain selection
    // ##########################################################

    genvar v;
    generate
        for (v = 0; v < NUM_VOICES; v++) begin : g_envelope
            adsr_modulator u_adsr_modulator (
                .clk_i              ( clk_i                 ),
                .rst_n_i            ( rst_n_i               ),
                .start_i            ( adsr_start_i[v]       ),
                .enable_i           ( adsr_enable_i[v]      ),
                .attack_step_i      ( attack_step_i[v]      ),
                .decay_step_i       ( decay_step_i[v]       ),
                .release_step_i     ( release_step_i[v]     ),
                .sustain_duration_i ( sustain_duration_i[v] ),
                .attack_level_i     ( attack_level_i[v]     ),
                .sustain_level_i    ( sustain_level_i[v]    ),
                .idle_o             ( adsr_idle_o[v]        ),
                .modulator_o        ( envelope[v]           )
            );

            assign wave_gain[v] = adsr_enable_i[v] ? envelope[v] : wave_gain_i[v];
        end
    endgenerate

    audio_generation_pipeline #(
        .TABLE_ADDR_W ( TABLE_ADDR_W )
    ) u_audio_generation_pipeline (
        .clk_i                    ( clk_i                    ),
        .rst_n_i                  ( rst_n_i                  ),
        .write_table_i            ( write_table_i            ),
        .table_addr_i             ( table_addr_i             ),
        .pcm_i                    ( pcm_i                    ),
        .wave_enable_i            ( wave_enable_i            ),
        .wave_start_i             ( wave_start_i             ),
        .wave_frequency_i         ( wave_frequency_i         ),
        .square_wave_duty_cycle_i ( square_wave_duty_cycle_i ),
        .wave_gain_i              ( wave_gain                ),
        .mixed_wave_o             ( mixed_wave_o             )
    );

endmodule : audio_synthesis_pipeline

`default_nettype wire

// File: rtl/custom_wave_table.sv
`timescale 1ns/1ps
`default_nettype none

module custom_wave_table #(
    parameter int TABLE_ADDR_W = 10
) (
    input  logic                                 clk_i,
    input  logic                                 write_i,
    input  logic [TABLE_ADDR_W-1:0]              write_addr_i,
    input  logic [TABLE_ADDR_W-1:0]              read_addr_i,
    input  logic signed [synth_pkg::SAMPLE_W-1:0] write_data_i,
    output logic signed [synth_pkg::SAMPLE_W-1:0] read_data_o
);
    import synth_pkg::*;

    logic signed [SAMPLE_W-1:0] table_mem [2**TABLE_ADDR_W];

    // The read register doubles as the shaping stage of the custom voice
    always_ff @(posedge clk_i) begin
        if (write_i) begin
            table_mem[write_addr_i] <= write_data_i;
        end
        read_data_o <= table_mem[read_addr_i];   // Old data on a same-cycle write
    end

endmodule : custom_wave_table

`default_nettype wire

// File: rtl/gain_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module gain_mixer (
    input  logic                                                      clk_i,
    input  logic                                                      rst_n_i,
    input  logic [synth_pkg::NUM_VOICES-1:0][synth_pkg::SAMPLE_W-1:0] sample_i,
    input  logic [synth_pkg::NUM_VOICES-1:0][synth_pkg::GAIN_W-1:0]   gain_i,
    output logic signed [synth_pkg::SAMPLE_W-1:0]                     mixed_o
);
    import synth_pkg::*;

    localparam int SUM_W = SAMPLE_W + $clog2(NUM_VOICES);

    logic [GAIN_W-1:0]                 gain_clamped [NUM_VOICES];
    logic signed [SAMPLE_W+GAIN_W:0]   full_prod    [NUM_VOICES];
    logic signed [SAMPLE_W-1:0]        product_q    [NUM_VOICES];
    logic signed [SUM_W-1:0]           sum;

    // ##########################################################
    // Stage 1: scale every voice
    // ##########################################################

    always_comb begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            gain_clamped[v] = (gain_i[v] > GAIN_ONE) ? GAIN_ONE : gain_i[v];
            full_prod[v]    = $signed(sample_i[v]) * $signed({1'b0, gain_clamped[v]});
        end
    end

    always_ff @(posedge clk_i) begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (!rst_n_i) product_q[v] <= '0;
            else          product_q[v] <= full_prod[v][SAMPLE_W+14:15];   // Gain of at most 1.0 fits
        end
    end

    // ##########################################################
    // Stage 2: sum and saturate
    // ##########################################################

    always_comb begin
        sum = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            sum = sum + product_q[v];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i)              mixed_o <= '0;
        else if (sum > SAMPLE_MAX) mixed_o <= SAMPLE_MAX;
        else if (sum < SAMPLE_MIN) mixed_o <= SAMPLE_MIN;
        else                       mixed_o <= sum[SAMPLE_W-1:0];
    end

endmodule : gain_mixer

`default_nettype wire

// File: rtl/synth_pkg.sv
`default_nettype none

package synth_pkg;

    // ##########################################################
    // Voice layout and widths
    // ##########################################################

    localparam int NUM_VOICES = 4;

    localparam int CUSTOM_WAVE   = 0;
    localparam int SINE_WAVE     = 1;
    localparam int TRIANGLE_WAVE = 2;
    localparam int SQUARE_WAVE   = 3;

    localparam int PHASE_W  = 32;   // Unsigned fraction of one period
    localparam int SAMPLE_W = 16;   // Signed PCM
    localparam int GAIN_W   = 16;   // Q1.15 unsigned
    localparam int ENV_W    = 32;   // Top GAIN_W bits drive the gain

    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = 16'sh7FFF;
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = 16'sh8000;
    localparam logic [GAIN_W-1:0]          GAIN_ONE   = 16'h8000;   // Unity gain in Q1.15

    // ##########################################################
    // Encodings
    // ##########################################################

    // Shape values follow the voice indices above
    typedef enum logic [1:0] {
        SHAPE_CUSTOM,
        SHAPE_SINE,
        SHAPE_TRIANGLE,
        SHAPE_SQUARE
    } wave_shape_e;

    typedef enum logic [2:0] {
        ADSR_IDLE,
        ADSR_ATTACK,
        ADSR_DECAY,
        ADSR_SUSTAIN,
        ADSR_RELEASE
    } adsr_state_e;

endpackage : synth_pkg

`default_nettype wire

// File: rtl/wave_oscillator.sv
`timescale 1ns/1ps
`default_nettype none

module wave_oscillator #(
    parameter synth_pkg::wave_shape_e SHAPE        = synth_pkg::SHAPE_SQUARE,
    parameter int                     TABLE_ADDR_W = 10
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 enable_i,
    input  logic                                 start_i,
    input  logic [synth_pkg::PHASE_W-1:0]        frequency_i,
    input  logic [synth_pkg::PHASE_W-1:0]        duty_cycle_i,
    input  logic signed [synth_pkg::SAMPLE_W-1:0] table_data_i,
    output logic [TABLE_ADDR_W-1:0]              table_addr_o,
    output logic signed [synth_pkg::SAMPLE_W-1:0] sample_o
);
    import synth_pkg::*;

    logic [PHASE_W-1:0] phase_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || start_i) begin
            phase_q <= '0;   // Start holds the voice at the top of its period
        end else begin
            phase_q <= phase_q + frequency_i;
        end
    end

    assign table_addr_o = phase_q[PHASE_W-1 -: TABLE_ADDR_W];

    generate
        if (SHAPE == SHAPE_CUSTOM) begin : g_custom
            logic enable_q;

            always_ff @(posedge clk_i) begin
                if (!rst_n_i) enable_q <= 1'b0;
                else          enable_q <= enable_i;
            end

            assign sample_o = enable_q ? table_data_i : '0;   // Table read is already registered
        end else begin : g_shaped
            logic [15:0]                top_phase;
            logic [14:0]                half_pos;   // Position inside the current half period
            logic [15:0]                half_rem;
            logic [30:0]                arc;
            logic [15:0]                arc_mag;
            logic signed [SAMPLE_W-1:0] shaped;
            logic signed [SAMPLE_W-1:0] sample_q;

            always_comb begin
                top_phase = phase_q[PHASE_W-1 -: 16];
                half_pos  = top_phase[14:0];
                half_rem  = 16'h8000 - {1'b0, half_pos};
                arc       = half_pos * half_rem;   // Peaks at 2^28 in the middle of a half
                arc_mag   = arc[28:13];

                case (SHAPE)
                    SHAPE_SINE: begin
                        if (arc_mag[15]) arc_mag = SAMPLE_MAX;
                        shaped = top_phase[15] ? -$signed(arc_mag) : $signed(arc_mag);
                    end
                    SHAPE_TRIANGLE: begin
                        // Flipping the MSB turns the offset ramp into two's complement
                        shaped = (phase_q[PHASE_W-1] ? ~phase_q[PHASE_W-2 -: 16]
                                                     : phase_q[PHASE_W-2 -: 16]) ^ 16'h8000;
                    end
                    default: shaped = (phase_q < duty_cycle_i) ? SAMPLE_MAX : -SAMPLE_MAX;
                endcase
            end

            always_ff @(posedge clk_i) begin
                if (!rst_n_i) sample_q <= '0;
                else          sample_q <= enable_i ? shaped : '0;
            end

            assign sample_o = sample_q;
        end
    endgenerate

    // The parabola clamp keeps the sine off the most negative code
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        SHAPE != SHAPE_SINE || sample_o != SAMPLE_MIN);

endmodule : wave_oscillator

`default_nettype wire

// File: verif/audio_synthesis_tests.svh
`ifndef AUDIO_SYNTHESIS_TESTS_SVH
`define AUDIO_SYNTHESIS_TESTS_SVH

// Holds every phase at zero long enough to flush the pipeline with new settings
task automatic restart_voices(input logic [NUM_VOICES-1:0] enable);
    @(negedge clk_i);
    wave_start_i  = '1;
    wave_enable_i = enable;
    repeat (4) @(negedge clk_i);
endtask

// Phase zero reaches the output three edges after the start is released
task automatic play_and_compare(input string name, input int samples, output int saturated);
    int                         raw;
    logic signed [SAMPLE_W-1:0] expected;
    saturated = 0;
    captured.delete();
    wave_start_i = '0;
    for (int m = 1; m < samples + 3; m++) begin
        @(negedge clk_i);
        if (m >= 3) begin
            raw      = mix_sum(m - 3);
            expected = SAMPLE_W'((raw > 32767) ? 32767 : ((raw < -32768) ? -32768 : raw));
            if (raw > 32767 || raw < -32768) saturated++;
            captured.push_back(mixed_wave_o);
            check_sample(name, expected, mixed_wave_o);
        end
    end
endtask

task automatic reset_behavior();
    repeat (4) begin
        @(negedge clk_i);
        check_sample("reset output", '0, mixed_wave_o);
        check_idle("reset idle", '1, adsr_idle_o);
    end
endtask

task automatic square_and_triangle();
    int                 saturated;
    logic [PHASE_W-1:0] duty [2] = '{32'h8000_0000, 32'h2000_0000};
    foreach (duty[i]) begin
        square_wave_duty_cycle_i = duty[i];
        wave_frequency_i         = {NUM_VOICES{32'h1000_0000}};   // 16 samples per period
        wave_gain_i              = {NUM_VOICES{16'h4000}};
        restart_voices(4'b1100);
        play_and_compare("square and triangle", 32, saturated);
    end
endtask

task automatic custom_table_playback();
    int saturated;
    for (int a = 0; a < 2**TABLE_ADDR_W; a++) begin
        @(negedge clk_i);
        write_table_i  = 1'b1;
        table_addr_i   = TABLE_ADDR_W'(a);
        pcm_i          = SAMPLE_W'($urandom);
        table_model[a] = pcm_i;
    end
    @(negedge clk_i);
    write_table_i                 = 1'b0;
    wave_frequency_i[CUSTOM_WAVE] = $urandom;
    wave_gain_i[CUSTOM_WAVE]      = GAIN_ONE;
    restart_voices(4'b0001);
    play_and_compare("custom table", 64, saturated);
endtask

task automatic sine_shape();
    int saturated;
    wave_frequency_i[SINE_WAVE] = 32'h0400_0000;   // 64 samples per period
    wave_gain_i[SINE_WAVE]      = GAIN_ONE;
    restart_voices(4'b0010);
    play_and_compare("sine period", 64, saturated);
    check_sample("sine quarter peak", 16'sh7FFF, captured[16]);
    check_sample("sine three-quarter peak", -16'sh7FFF, captured[48]);
endtask

task automatic mixing_saturation();
    int saturated;
    square_wave_duty_cycle_i = '1;   // Square sits at full positive
    for (int v = 0; v < NUM_VOICES; v++) begin
        wave_frequency_i[v] = $urandom;
        wave_gain_i[v]      = GAIN_ONE;
    end
    restart_voices('1);
    play_and_compare("mixing saturation", 64, saturated);
    if (saturated == 0) begin
        $display("Mixing saturation test never drove the sum out of range");
        stop_with_failure();
    end
endtask

task automatic adsr_envelope();
    int attack_n;
    int total;
    int magnitude;
    int previous;
    attack_step_i[TRIANGLE_WAVE]      = 32'h1000_0000;
    attack_level_i[TRIANGLE_WAVE]     = 32'h6000_0000;
    decay_step_i[TRIANGLE_WAVE]       = 32'h0800_0000;
    sustain_level_i[TRIANGLE_WAVE]    = 32'h3000_0000;
    sustain_duration_i[TRIANGLE_WAVE] = 5;
    release_step_i[TRIANGLE_WAVE]     = 32'h0400_0000;
    adsr_enable_i[TRIANGLE_WAVE]      = 1'b1;
    restart_voices(4'b0100);   // Phase stays at zero so the triangle holds full negative
    adsr_start_i[TRIANGLE_WAVE] = 1'b1;
    attack_n = ceil_steps(attack_level_i[TRIANGLE_WAVE], attack_step_i[TRIANGLE_WAVE]);
    total    = attack_n
             + ceil_steps(longint'(attack_level_i[TRIANGLE_WAVE])
                          - longint'(sustain_level_i[TRIANGLE_WAVE]), decay_step_i[TRIANGLE_WAVE])
             + ceil_steps(sustain_duration_i[TRIANGLE_WAVE], 1)
             + ceil_steps(sustain_level_i[TRIANGLE_WAVE], release_step_i[TRIANGLE_WAVE]);
    previous = 0;
    for (int m = 1; m <= total + 1; m++) begin
        @(negedge clk_i);
        adsr_start_i = '0;
        check_idle("adsr idle", (m <= total) ? 4'b1011 : 4'b1111, adsr_idle_o);
        magnitude = -int'(mixed_wave_o);
        if (m <= attack_n + 4 && magnitude < previous) begin
            $display("ADSR attack: output magnitude fell from %0d to %0d", previous, magnitude);
            stop_with_failure();
        end
        // The attack target reaches the output three edges after the level clamps
        if (m == attack_n + 4) check_sample("adsr attack peak", -16'sh6000, mixed_wave_o);
        previous = magnitude;
    end
endtask

`endif

// File: verif/audio_synthesis_tb.sv
`timescale 1ns/1ps
`default_nettype none

module audio_synthesis_tb;
    import synth_pkg::*;

    localparam int TABLE_ADDR_W = 10;
    localparam int CLK_PERIOD   = 10;
    // Budgets for reset, square/triangle, table, sine, saturation and ADSR tests
    localparam int TEST_CYCLES  = 20 + 100 + (2**TABLE_ADDR_W + 100) + 100 + 100 + 80;

    logic                               clk_i;
    logic                               rst_n_i;
    logic [NUM_VOICES-1:0]              adsr_start_i, adsr_enable_i, adsr_idle_o;
    logic [NUM_VOICES-1:0][ENV_W-1:0]   attack_step_i, decay_step_i, release_step_i;
    logic [NUM_VOICES-1:0][ENV_W-1:0]   sustain_duration_i, attack_level_i, sustain_level_i;
    logic                               write_table_i;
    logic [TABLE_ADDR_W-1:0]            table_addr_i;
    logic signed [SAMPLE_W-1:0]         pcm_i;
    logic [NUM_VOICES-1:0]              wave_enable_i, wave_start_i;
    logic [NUM_VOICES-1:0][PHASE_W-1:0] wave_frequency_i;
    logic [PHASE_W-1:0]                 square_wave_duty_cycle_i;
    logic [NUM_VOICES-1:0][GAIN_W-1:0]  wave_gain_i;
    logic signed [SAMPLE_W-1:0]         mixed_wave_o;

    logic signed [SAMPLE_W-1:0] table_model [2**TABLE_ADDR_W];   // Mirror of the custom table
    logic signed [SAMPLE_W-1:0] captured [$];   // Outputs of the last playback, indexed by step

    audio_synthesis_pipeline #(.TABLE_ADDR_W(TABLE_ADDR_W)) u_audio_synthesis_pipeline (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_sample(input string name, input logic signed [SAMPLE_W-1:0] expected,
                                input logic signed [SAMPLE_W-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_idle(input string name, input logic [NUM_VOICES-1:0] expected,
                              input logic [NUM_VOICES-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            stop_with_failure();
        end
    endtask

    // ##########################################################
    // Reference model
    // ##########################################################

    // Raw output of one voice at phase p, as an unsigned fraction of a period
    function automatic int shape_sample(int voice, logic [PHASE_W-1:0] p);
        int h;
        int mag;
        case (voice)
            SQUARE_WAVE:   return (p < square_wave_duty_cycle_i) ? 32767 : -32767;
            TRIANGLE_WAVE: return p[31] ? 32767 - int'(p[30:15]) : int'(p[30:15]) - 32768;
            SINE_WAVE: begin
                h   = int'(p[30:16]);   // Position inside the half period
                mag = (h * (32768 - h)) / 8192;   // Parabola reaching 2^15 mid-half
                if (mag > 32767) mag = 32767;
                return p[31] ? -mag : mag;
            end
            default: return table_model[p[31 -: TABLE_ADDR_W]];
        endcase
    endfunction

    // Unsaturated sum of all scaled voices, step cycles after the phases restart
    function automatic int mix_sum(int step);
        int sum;
        int gain;
        sum = 0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            gain = (wave_gain_i[v] > GAIN_ONE) ? GAIN_ONE : wave_gain_i[v];
            if (wave_enable_i[v]) begin
                sum += (shape_sample(v, wave_frequency_i[v] * PHASE_W'(step)) * gain) >>> 15;
            end
        end
        return sum;
    endfunction

    // Length of one envelope phase in cycles, never less than one
    function automatic int ceil_steps(longint span, longint step);
        return (span <= step) ? 1 : int'((span + step - 1) / step);
    endfunction

    initial begin
        void'($urandom(32'h978f_6673));
        rst_n_i                  = 1'b0;
        adsr_start_i             = '0;
        adsr_enable_i            = '0;
        attack_step_i            = '0;
        decay_step_i             = '0;
        release_step_i           = '0;
        sustain_duration_i       = '0;
        attack_level_i           = '0;
        sustain_level_i          = '0;
        write_table_i            = 1'b0;
        table_addr_i             = '0;
        pcm_i                    = '0;
        wave_enable_i            = '0;
        wave_start_i             = '0;
        wave_frequency_i         = '0;
        square_wave_duty_cycle_i = '0;
        wave_gain_i              = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        reset_behavior();
        square_and_triangle();
        custom_table_playback();
        sine_shape();
        mixing_saturation();
        adsr_envelope();
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout: the tests did not finish within their cycle budget");
        stop_with_failure();
    end

    `include "audio_synthesis_tests.svh"

endmodule : audio_synthesis_tb

`default_nettype wire
